// ==== test/rvCoreTrace.txt ====
# name instr rd data nextPc illegal, all hex after the name
# rd and data are zero when the instruction writes no register
addi_x1_5        00500093 01 00000005 00000004 0
addi_x2_m3       ffd00113 02 fffffffd 00000008 0
slti_x3          00012193 03 00000001 0000000c 0
sltiu_x4         0060b213 04 00000001 00000010 0
xori_x5          0ff0c293 05 000000fa 00000014 0
ori_x6           0a00e313 06 000000a5 00000018 0
andi_x7          0f017393 07 000000f0 0000001c 0
slli_x8          00409413 08 00000050 00000020 0
srli_x9          01c15493 09 0000000f 00000024 0
srai_x10         40115513 0a fffffffe 00000028 0
add_x11          002085b3 0b 00000002 0000002c 0
sub_x12          40158633 0c fffffffd 00000030 0
slt_x13          001626b3 0d 00000001 00000034 0
sltu_x14         00163733 0e 00000000 00000038 0
sra_x15          401657b3 0f ffffffff 0000003c 0
srl_x16          00165833 10 07ffffff 00000040 0
sll_x17          001098b3 11 000000a0 00000044 0
xor_x18          00734933 12 00000055 00000048 0
or_x19           009469b3 13 0000005f 0000004c 0
and_x20          01397a33 14 00000055 00000050 0
lui_x21          12345ab7 15 12345000 00000054 0
auipc_x22        00001b17 16 00001054 00000058 0
beq_taken        00108463 00 00000000 00000060 0
beq_not_taken    00208463 00 00000000 00000064 0
bne_taken        00209463 00 00000000 0000006c 0
bne_not_taken    00109463 00 00000000 00000070 0
blt_taken        00114463 00 00000000 00000078 0
blt_not_taken    0020c463 00 00000000 0000007c 0
bge_taken        0020d463 00 00000000 00000084 0
bge_not_taken    00115463 00 00000000 00000088 0
bltu_taken       0020e463 00 00000000 00000090 0
bltu_not_taken   00116463 00 00000000 00000094 0
bgeu_taken       00117463 00 00000000 0000009c 0
bgeu_not_taken   0020f463 00 00000000 000000a0 0
bne_backward     fe0098e3 00 00000000 00000090 0
jal_x23          02000bef 17 00000094 000000b0 0
jalr_x24         00708c67 18 000000b4 0000000c 0
jal_x0_back      ffdff06f 00 00000000 00000008 0
addi_x0          00508013 00 00000000 0000000c 0
add_x25_from_x0  00100cb3 19 00000005 00000010 0
lw_x1_illegal    00002083 00 00000000 00000014 1
addi_x26_from_x1 00008d13 1a 00000005 00000018 0

// ==== verilog.f ====
hdl/rvPkg.sv
hdl/instrDecoder.sv
hdl/regFile.sv
hdl/alu.sv
hdl/branchUnit.sv
hdl/commitUnit.sv
hdl/rvCore.sv
test/rvCoreTb.sv

// ==== Makefile ====
.PHONY: all run clean

all: obj_dir/VrvCoreTb

# rebuilt only when a source or the file list changes
obj_dir/VrvCoreTb: verilog.f $(wildcard hdl/*.sv) test/rvCoreTb.sv
	verilator --binary --timing --top-module rvCoreTb -f verilog.f -o VrvCoreTb

# exit status of the binary is the test result
run: obj_dir/VrvCoreTb test/rvCoreTrace.txt
	./obj_dir/VrvCoreTb

clean:
	rm -rf obj_dir

// ==== test/rvCoreTb.sv ====
module rvCoreTb import rvPkg::*; ();

    localparam int retireTimeout = 10; // cycles allowed from strobe to retire

    logic       clk;
    logic       rstN;
    logic       instrValid;
    Instruction instr;
    logic       retireValid;
    RetireInfo  retire;

    int     fd;
    int     lineNo;
    int     checked;
    int     count;
    int     split;
    string  line;
    string  testName;
    Word    instrWord;
    RegAddr expRd;
    Word    expData;
    Word    expNextPc;
    logic   expIllegal;

    rvCore DUT (
        .clk         (clk),
        .rstN        (rstN),
        .instrValid  (instrValid),
        .instr       (instr),
        .retireValid (retireValid),
        .retire      (retire)
    );

    always #2 clk = ~clk; // period of 4

    task automatic abortRun(input string why);
        $display("%0s", why);
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic compareAddr(input string name, input RegAddr expected, input RegAddr actual);
        if (expected !== actual) begin
            abortRun($sformatf("Fail %0s: expected %h, actual %h", name, expected, actual));
        end
    endtask

    task automatic compareWord(input string name, input Word expected, input Word actual);
        if (expected !== actual) begin
            abortRun($sformatf("Fail %0s: expected %h, actual %h", name, expected, actual));
        end
    endtask

    task automatic compareFlag(input string name, input logic expected, input logic actual);
        if (expected !== actual) begin
            abortRun($sformatf("Fail %0s: expected %b, actual %b", name, expected, actual));
        end
    endtask

    // first blank in a trace line ends the test name
    function automatic int findBlank(input string s);
        int pos;
        pos = s.len();
        for (int i = s.len() - 1; i >= 0; i--) begin
            if (s.getc(i) == " " || s.getc(i) == "\t") begin
                pos = i;
            end
        end
        return pos;
    endfunction

    task automatic issueAndCheck(input string name, input Word word, input RegAddr rd,
                                 input Word data, input Word nextPc, input logic illegal);
        int waited;
        waited = 0;
        instr = Instruction'(word);
        instrValid = 1'b1;
        do begin
            @(posedge clk);
            #1;
            instrValid = 1'b0; // strobe lasts one cycle
            waited++;
        end while (!retireValid && waited < retireTimeout);
        if (!retireValid) begin
            abortRun($sformatf("%0s did not retire within %0d cycles", name, retireTimeout));
        end else begin
            if (waited != 1) begin
                abortRun($sformatf("Fail %0s latency: expected 1, actual %0d", name, waited));
            end
            compareAddr({name, " rd"}, rd, retire.rd);
            compareWord({name, " data"}, data, retire.data);
            compareWord({name, " nextPc"}, nextPc, retire.nextPc);
            compareFlag({name, " illegal"}, illegal, retire.illegal);
        end
    endtask

    initial begin
        clk = 1'b0;
        rstN = 1'b0;
        instrValid = 1'b0;
        instr = '0;
        lineNo = 0;
        checked = 0;
        repeat (8) @(posedge clk);
        #1;
        rstN = 1'b1;
        compareFlag("reset retireValid", 1'b0, retireValid);

        fd = $fopen("test/rvCoreTrace.txt", "r");
        if (fd == 0) begin
            abortRun("could not open test/rvCoreTrace.txt");
        end else begin
            while (!$feof(fd)) begin
                count = $fgets(line, fd);
                lineNo++;
                if (count > 0 && line.len() > 1 && line.getc(0) != "#") begin
                    split = findBlank(line);
                    testName = line.substr(0, split - 1);
                    count = $sscanf(line.substr(split, line.len() - 1), "%h %h %h %h %h",
                                    instrWord, expRd, expData, expNextPc, expIllegal);
                    if (count != 5) begin
                        abortRun($sformatf("trace line %0d could not be parsed", lineNo));
                    end else begin
                        issueAndCheck(testName, instrWord, expRd, expData, expNextPc,
                                      expIllegal);
                        checked++;
                    end
                end
            end
            $fclose(fd);
            @(posedge clk);
            #1;
            compareFlag("idle retireValid", 1'b0, retireValid); // pulse ends without a strobe
            if (checked == 0) begin
                abortRun("trace file held no instructions");
            end else begin
                $display("*** PASSED ***");
                $finish;
            end
        end
    end

endmodule

// ==== hdl/rvCore.sv ====
module rvCore import rvPkg::*; (
    input  logic       clk,
    input  logic       rstN,
    input  logic       instrValid,
    input  Instruction instr,
    output logic       retireValid,
    output RetireInfo  retire
);

    DecodedInstr dec;
    ExecResult   exec;
    Word         rs1Data;
    Word         rs2Data;
    Word         opA;
    Word         opB;
    Word         aluOut;
    logic        taken;
    Word         target;
    Word         pc;
    logic        wrEn;
    RegAddr      wrAddr;
    Word         wrData;

    instrDecoder decoder (
        .instr (instr),
        .dec   (dec)
    );

    regFile regs (
        .clk     (clk),
        .rstN    (rstN),
        .rs1Addr (dec.rs1),
        .rs2Addr (dec.rs2),
        .wrEn    (wrEn),
        .wrAddr  (wrAddr),
        .wrData  (wrData),
        .rs1Data (rs1Data),
        .rs2Data (rs2Data)
    );

    assign opA = dec.usePcA ? pc : rs1Data; // auipc
    assign opB = dec.useImm ? dec.imm : rs2Data;

    alu aluInst (
        .cmd    (dec.aluCmd),
        .a      (opA),
        .b      (opB),
        .result (aluOut)
    );

    branchUnit branch (
        .cond     (dec.cond),
        .isBranch (dec.isBranch),
        .isJal    (dec.isJal),
        .isJalr   (dec.isJalr),
        .rs1Val   (rs1Data),
        .rs2Val   (rs2Data),
        .imm      (dec.imm),
        .pc       (pc),
        .taken    (taken),
        .target   (target)
    );

    assign exec = '{aluOut: aluOut, taken: taken, target: target};

    commitUnit commit (
        .clk         (clk),
        .rstN        (rstN),
        .instrValid  (instrValid),
        .dec         (dec),
        .exec        (exec),
        .pc          (pc),
        .wrEn        (wrEn),
        .wrAddr      (wrAddr),
        .wrData      (wrData),
        .retireValid (retireValid),
        .retire      (retire)
    );

endmodule

// ==== hdl/commitUnit.sv ====
module commitUnit import rvPkg::*; (
    input  logic        clk,
    input  logic        rstN,
    input  logic        instrValid,
    input  DecodedInstr dec,
    input  ExecResult   exec,
    output Word         pc,
    output logic        wrEn,
    output RegAddr      wrAddr,
    output Word         wrData,
    output logic        retireValid,
    output RetireInfo   retire
);

    Word  pcPlus4;
    Word  nextPc;
    logic isJump;

    assign pcPlus4 = pc + 32'd4;
    assign isJump = dec.isJal | dec.isJalr;

    // illegal instructions never set taken, so they fall through to pc+4
    assign nextPc = exec.taken ? exec.target : pcPlus4;

    // register file write lands on the retire edge
    assign wrEn = instrValid & dec.writesRd & ~dec.illegal & (dec.rd != '0);
    assign wrAddr = dec.rd;
    assign wrData = isJump ? pcPlus4 : exec.aluOut; // link address for jumps

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc <= resetPc;
            retireValid <= 1'b0;
        end else begin
            retireValid <= instrValid; // one cycle after the strobe
            if (instrValid) begin
                pc <= nextPc;
            end
        end
    end

    // zeros in rd and data when nothing was written
    always_ff @(posedge clk) begin
        if (instrValid) begin
            retire.rd <= wrEn ? wrAddr : '0;
            retire.data <= wrEn ? wrData : '0;
            retire.nextPc <= nextPc;
            retire.illegal <= dec.illegal;
        end
    end

endmodule

// ==== hdl/branchUnit.sv ====
module branchUnit import rvPkg::*; (
    input  BranchCond cond,
    input  logic      isBranch,
    input  logic      isJal,
    input  logic      isJalr,
    input  Word       rs1Val,
    input  Word       rs2Val,
    input  Word       imm,
    input  Word       pc,
    output logic      taken,
    output Word       target
);

    logic condMet;
    Word  jalrSum;

    always_comb begin
        case (cond)
            BEQ:     condMet = (rs1Val == rs2Val);
            BNE:     condMet = (rs1Val != rs2Val);
            BLT:     condMet = ($signed(rs1Val) < $signed(rs2Val));
            BGE:     condMet = ($signed(rs1Val) >= $signed(rs2Val));
            BLTU:    condMet = (rs1Val < rs2Val);
            BGEU:    condMet = (rs1Val >= rs2Val);
            default: condMet = 1'b0;
        endcase
    end

    // jumps are always taken
    assign taken = (isBranch & condMet) | isJal | isJalr;

    assign jalrSum = rs1Val + imm;
    assign target = isJalr ? {jalrSum[31:1], 1'b0} : pc + imm; // jalr drops bit 0

endmodule

// ==== hdl/alu.sv ====
module alu import rvPkg::*; (
    input  AluCmd cmd,
    input  Word   a,
    input  Word   b,
    output Word   result
);

    logic [4:0] shamt;
    logic       ltSigned;
    logic       ltUnsigned;

    assign shamt = b[4:0]; // upper bits of b ignored for shifts
    assign ltSigned = $signed(a) < $signed(b);
    assign ltUnsigned = a < b;

    always_comb begin
        case (cmd)
            ADD:     result = a + b;
            SUB:     result = a - b;
            SLL:     result = a << shamt;
            SLT:     result = {31'b0, ltSigned};
            SLTU:    result = {31'b0, ltUnsigned};
            XOR:     result = a ^ b;
            SRL:     result = a >> shamt;
            SRA:     result = Word'($signed(a) >>> shamt); // sign fills from the top
            OR:      result = a | b;
            AND:     result = a & b;
            PASSB:   result = b;
            default: result = '0;
        endcase
    end

endmodule

// ==== hdl/regFile.sv ====
module regFile import rvPkg::*; (
    input  logic   clk,
    input  logic   rstN,
    input  RegAddr rs1Addr,
    input  RegAddr rs2Addr,
    input  logic   wrEn,
    input  RegAddr wrAddr,
    input  Word    wrData,
    output Word    rs1Data,
    output Word    rs2Data
);

    Word regs [32];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn && wrAddr != '0) begin
            regs[wrAddr] <= wrData; // x0 never written
        end
    end

    // x0 forced to zero on read as well
    assign rs1Data = (rs1Addr == '0) ? '0 : regs[rs1Addr];
    assign rs2Data = (rs2Addr == '0) ? '0 : regs[rs2Addr];

endmodule

// ==== hdl/instrDecoder.sv ====
module instrDecoder import rvPkg::*; (
    input  Instruction  instr,
    output DecodedInstr dec
);

    Word   immI;
    Word   immU;
    Word   immB;
    Word   immJ;
    AluCmd funcCmd;
    logic  altFunc;
    logic  badCond;

    // bit 30 selects SUB and SRA in both formats
    assign altFunc = instr.ip.rr.funct7[5];

    // funct3 010 and 011 have no branch meaning
    assign badCond = (instr.ip.b.funct3[2:1] == 2'b01);

    assign immI = {{20{instr.ip.ri.imm[11]}}, instr.ip.ri.imm};
    assign immU = {instr.ip.u.imm, 12'b0};

    assign immB = {
        {19{instr.ip.b.sign}},
        instr.ip.b.sign,
        instr.ip.b.offsetMsb,
        instr.ip.b.offsetHigh,
        instr.ip.b.offsetLow,
        1'b0
    };

    assign immJ = {
        {11{instr.ip.j.sign}},
        instr.ip.j.sign,
        instr.ip.j.imm19to12,
        instr.ip.j.imm11,
        instr.ip.j.imm10to1,
        1'b0
    };

    always_comb begin
        unique case (instr.ip.rr.funct3)
            3'b000: funcCmd = (instr.opCode == OP && altFunc) ? SUB : ADD;
            3'b001: funcCmd = SLL;
            3'b010: funcCmd = SLT;
            3'b011: funcCmd = SLTU;
            3'b100: funcCmd = XOR;
            3'b101: funcCmd = altFunc ? SRA : SRL;
            3'b110: funcCmd = OR;
            3'b111: funcCmd = AND;
        endcase
    end

    always_comb begin
        dec = '0;
        dec.rs1 = instr.ip.rr.rs1;
        dec.rs2 = instr.ip.rr.rs2;
        dec.rd = instr.ip.rr.rd;
        dec.aluCmd = funcCmd;
        dec.cond = BranchCond'(instr.ip.b.funct3);

        case (instr.opCode)
            OP: begin
                dec.writesRd = 1'b1;
            end
            OP_IMM: begin
                dec.imm = immI;
                dec.useImm = 1'b1;
                dec.writesRd = 1'b1;
            end
            LUI: begin
                dec.imm = immU;
                dec.useImm = 1'b1;
                dec.aluCmd = PASSB;
                dec.writesRd = 1'b1;
            end
            AUIPC: begin
                dec.imm = immU;
                dec.useImm = 1'b1;
                dec.usePcA = 1'b1;
                dec.aluCmd = ADD;
                dec.writesRd = 1'b1;
            end
            BRANCH: begin
                dec.imm = immB;
                dec.isBranch = !badCond;
                dec.illegal = badCond;
            end
            JAL: begin
                dec.imm = immJ;
                dec.isJal = 1'b1;
                dec.writesRd = 1'b1;
            end
            JALR: begin
                dec.imm = immI;
                dec.isJalr = 1'b1;
                dec.writesRd = 1'b1;
            end
            default: begin
                dec.illegal = 1'b1; // load, store, system and unknowns
            end
        endcase
    end

endmodule

// ==== hdl/rvPkg.sv ====
package rvPkg;

    typedef logic [31:0] Word;
    typedef logic [4:0]  RegAddr;

    localparam Word resetPc = '0;

    // major opcodes, instr[6:2]
    typedef enum logic [4:0] {
        LOAD   = 5'b00000,
        STORE  = 5'b01000,
        OP_IMM = 5'b00100,
        OP     = 5'b01100,
        LUI    = 5'b01101,
        AUIPC  = 5'b00101,
        BRANCH = 5'b11000,
        JAL    = 5'b11011,
        JALR   = 5'b11001,
        SYSTEM = 5'b11100
    } OpCode;

    typedef enum logic [3:0] {
        ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND,
        PASSB // operand b straight through, for LUI
    } AluCmd;

    // encoded as the branch funct3
    typedef enum logic [2:0] {
        BEQ  = 3'b000,
        BNE  = 3'b001,
        BLT  = 3'b100,
        BGE  = 3'b101,
        BLTU = 3'b110,
        BGEU = 3'b111
    } BranchCond;

    typedef struct packed {
        logic [11:0] imm;
        RegAddr      rs1;
        logic [2:0]  funct3;
        RegAddr      rd;
    } RegisterImmediateInstr;

    typedef struct packed {
        logic [6:0] funct7;
        RegAddr     rs2;
        RegAddr     rs1;
        logic [2:0] funct3;
        RegAddr     rd;
    } RegisterRegisterInstr;

    typedef struct packed {
        logic       sign;       // imm[12]
        logic [5:0] offsetHigh; // imm[10:5]
        RegAddr     rs2;
        RegAddr     rs1;
        logic [2:0] funct3;
        logic [3:0] offsetLow;  // imm[4:1]
        logic       offsetMsb;  // imm[11]
    } BranchingInstr;

    typedef struct packed {
        logic [19:0] imm; // imm[31:12]
        RegAddr      rd;
    } UpperImmInstr;

    typedef struct packed {
        logic       sign;     // imm[20]
        logic [9:0] imm10to1;
        logic       imm11;
        logic [7:0] imm19to12;
        RegAddr     rd;
    } JumpInstr;

    typedef union packed {
        RegisterImmediateInstr ri;
        RegisterRegisterInstr  rr;
        BranchingInstr         b;
        UpperImmInstr          u;
        JumpInstr              j;
    } InstructionPayload;

    typedef struct packed {
        InstructionPayload ip;
        OpCode             opCode;
        logic [1:0]        unusedAlways11;
    } Instruction;

    typedef struct packed {
        RegAddr    rs1;
        RegAddr    rs2;
        RegAddr    rd;
        Word       imm;
        AluCmd     aluCmd;
        logic      useImm;   // operand b from imm
        logic      usePcA;   // operand a from pc
        logic      writesRd;
        logic      isBranch;
        logic      isJal;
        logic      isJalr;
        logic      illegal;
        BranchCond cond;
    } DecodedInstr;

    typedef struct packed {
        Word  aluOut;
        logic taken;
        Word  target;
    } ExecResult;

    typedef struct packed {
        RegAddr rd;
        Word    data;
        Word    nextPc;
        logic   illegal;
    } RetireInfo;

endpackage
